// File: tile_render.f
+incdir+.
tile_render_pkg.sv
tile_map_lookup.sv
sprite_bitmap_rom.sv
pixel_colorizer.sv
tile_render.sv
tile_render_asserts.sv
tile_render_checker.sv
tile_render_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tile_render_tb
FILELIST = tile_render.f
SIM_ARGS = +verilator+error+limit+1000
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: tile_render_tb.sv
`timescale 1ns/1ps
`include "tile_render_params.svh"

module tile_render_tb;
	import tile_render_pkg::*;

	localparam int NUM_PIXELS     = 3000;
	localparam int REPORT_TIMEOUT = 20; // cycles

	logic     clock_50;
	logic     reset;
	logic     video_on;
	pix_pos_t pix;
	rgb_t     rgb;
	logic     done;
	logic     report_done;
	int       error_count;
	integer   seed;

	tile_render tile_render_i (
		.clock_50 (clock_50),
		.reset    (reset),
		.video_on (video_on),
		.pix      (pix),
		.rgb      (rgb)
	);

	tile_render_checker tile_render_checker_i (
		.clock_50    (clock_50),
		.reset       (reset),
		.video_on    (video_on),
		.pix         (pix),
		.rgb         (rgb),
		.done        (done),
		.report_done (report_done),
		.error_count (error_count)
	);

	bind tile_render tile_render_asserts tile_render_asserts_i (.*);

	initial begin
		clock_50 = 1'b0;
		forever #20 clock_50 = ~clock_50;
	end

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % 32'(n));
	endfunction

	// mostly uniform over the screen, sometimes aimed at rare tiles
	task automatic drive_pixel();
		int col;
		int row;
		if (rand_below(8) == 0) begin
			case (rand_below(4))
				0:       begin col = 0;  row = 9; end // robot
				1:       begin col = 9;  row = 2; end // trash
				2:       begin col = 9;  row = 6; end // code 4
				default: begin col = 13; row = 9; end // code 5
			endcase
			pix.x = 10'(col * `TILE_SIZE + rand_below(`TILE_SIZE));
			pix.y = 10'(row * `TILE_SIZE + rand_below(`TILE_SIZE));
		end else begin
			pix.x = 10'(rand_below(640));
			pix.y = 10'(rand_below(480));
		end
		video_on = (rand_below(8) != 0);
	endtask

	initial begin
		int waited;
		int assert_fails;
		seed = 32'h7417_2c0b;
		reset = 1'b1;
		video_on = 1'b0;
		pix = '0;
		done = 1'b0;
		waited = 0;
		repeat (4) @(posedge clock_50);
		@(negedge clock_50);
		reset = 1'b0;
		repeat (NUM_PIXELS) begin
			drive_pixel();
			@(negedge clock_50);
		end
		done = 1'b1;
		while (!report_done && waited < REPORT_TIMEOUT) begin
			@(posedge clock_50);
			waited++;
		end
		@(negedge clock_50); // assertion actions of the last edge are done
		assert_fails = tile_render_i.tile_render_asserts_i.failures;
		if (!report_done) begin
			$display("checker did not report within %0d cycles", REPORT_TIMEOUT);
			$display("Regression failed");
		end else if (error_count == 0 && assert_fails == 0) begin
			$display("Regression passed");
		end else begin
			$display("assertion failures %0d", assert_fails);
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: tile_render_checker.sv
`timescale 1ns/1ps
`include "tile_render_params.svh"

module tile_render_checker (
	input  logic                      clock_50,
	input  logic                      reset,
	input  logic                      video_on,
	input  tile_render_pkg::pix_pos_t pix,
	input  tile_render_pkg::rgb_t     rgb,
	input  logic                      done,
	output logic                      report_done,
	output int                        error_count
);
	import tile_render_pkg::*;

	localparam int NUM_TESTS = 5;
	localparam logic [2:0] T_RESET  = 3'd0;
	localparam logic [2:0] T_BLANK  = 3'd1;
	localparam logic [2:0] T_MAP    = 3'd2;
	localparam logic [2:0] T_BORDER = 3'd3;
	localparam logic [2:0] T_SPRITE = 3'd4;
	localparam logic [1:0] MODE_EXACT = 2'd0;
	localparam logic [1:0] MODE_ROBOT = 2'd1; // any robot palette color
	localparam logic [1:0] MODE_TRASH = 2'd2;

	localparam rgb_t C_BLACK = {3{`COLOR_BLACK}};
	localparam rgb_t C_WHITE = {3{`COLOR_WHITE}};
	localparam rgb_t C_GREY  = {3{`COLOR_GREY}};
	localparam rgb_t C_DGREY = {3{`COLOR_DARK_GREY}};

	typedef struct packed {
		logic     reset;
		logic     video_on;
		pix_pos_t pix;
	} sample_t;

	typedef struct packed {
		rgb_t       color;
		logic [1:0] mode;
		logic [2:0] test;
	} expect_t;

	// reference map, column 0 leftmost
	string map_rows [`MAP_DEFINED_ROWS] = '{
		"00000000011111100000", "00000000010000100000", "00000100030000111111",
		"00000111110000000000", "00000100010000001111", "00000100010001111000",
		"11111100041111000000", "10011100000010111111", "10000100000010010000",
		"20011111110115110000"
	};
	string   names [NUM_TESTS] = '{"reset", "blanking", "map_layout", "tile_border",
		"sprite_palette"};
	int      checks [NUM_TESTS];
	int      errors [NUM_TESTS];
	int      err_total = 0;
	bit      reported = 0;
	bit      done_seen = 0; // done as seen on the rising edge
	sample_t samples [$]; // last two samples
	expect_t pending [$];

	assign error_count = err_total;
	assign report_done = reported;

	function automatic expect_t expected_for(input sample_t s);
		expect_t    e;
		int         row;
		int         col;
		int         ox;
		int         oy;
		logic [2:0] code;
		logic       edge_px;
		row = int'(s.pix.y) / `TILE_SIZE;
		col = int'(s.pix.x) / `TILE_SIZE;
		ox = int'(s.pix.x) % `TILE_SIZE;
		oy = int'(s.pix.y) % `TILE_SIZE;
		edge_px = (ox == 0) || (ox == `TILE_SIZE - 1) || (oy == 0) || (oy == `TILE_SIZE - 1);
		e.mode = MODE_EXACT;
		if (!s.video_on) begin
			e.color = `COLOR_PINK;
			e.test = T_BLANK;
			return e;
		end
		if (row >= `MAP_DEFINED_ROWS) begin
			code = 3'd0; // solid wall rows
			e.test = T_MAP;
		end else begin
			code = 3'(map_rows[row][col] - 8'h30);
			e.test = (code >= 3'd4) ? T_MAP : ((code <= 3'd1) ? T_BORDER : T_SPRITE);
		end
		case (code)
			3'd0: e.color = edge_px ? C_BLACK : C_WHITE;
			3'd1: e.color = edge_px ? C_BLACK : C_GREY;
			3'd2, 3'd3: begin
				e.color = C_BLACK; // sprite frame
				if (!edge_px) e.mode = (code == 3'd2) ? MODE_ROBOT : MODE_TRASH;
			end
			default: e.color = `COLOR_RED;
		endcase
		return e;
	endfunction

	function automatic bit in_palette(input rgb_t c, input logic [1:0] mode);
		if (mode == MODE_ROBOT)
			return c inside {C_BLACK, C_WHITE, C_GREY, C_DGREY, `COLOR_YELLOW, `COLOR_RED,
				`COLOR_BROWN};
		return c inside {C_BLACK, C_GREY, C_DGREY, `COLOR_RED};
	endfunction

	// output after edge n depends on reset at n and the sample from edge n-1
	always @(posedge clock_50) begin
		sample_t cur;
		expect_t e;
		cur = '{reset: reset, video_on: video_on, pix: pix};
		if (reset || samples.size() == 0) begin
			e = '{color: C_BLACK, mode: MODE_EXACT, test: T_RESET};
		end else if (samples[$].reset) begin
			e = '{color: `COLOR_PINK, mode: MODE_EXACT, test: T_RESET}; // stage 1 reset value
		end else begin
			e = expected_for(samples[$]);
		end
		pending.push_back(e);
		samples.push_back(cur);
		if (samples.size() > 2) void'(samples.pop_front());
		if (done) done_seen = 1'b1;
	end

	always @(negedge clock_50) begin
		expect_t e;
		bit      ok;
		if (pending.size() > 0 && !reported) begin
			e = pending.pop_front();
			ok = (e.mode == MODE_EXACT) ? (rgb === e.color) : in_palette(rgb, e.mode);
			checks[e.test]++;
			if (!ok) begin
				errors[e.test]++;
				err_total++;
				if (e.mode == MODE_EXACT)
					$display("Error: test %s expected %h actual %h", names[e.test], e.color, rgb);
				else
					$display("Error: test %s expected %s palette color actual %h", names[e.test],
						(e.mode == MODE_ROBOT) ? "a robot" : "a trash", rgb);
			end
		end
		if (done_seen && !reported) begin
			for (int t = 0; t < NUM_TESTS; t++) begin
				$display("test %-14s checks %0d errors %0d", names[t], checks[t], errors[t]);
				if (checks[t] == 0) begin
					$display("test %s was never exercised by the stimulus", names[t]);
					err_total++;
				end
			end
			$display("total checks %0d errors %0d", checks.sum(), err_total);
			reported = 1'b1;
		end
	end

endmodule

// File: tile_render_asserts.sv
`timescale 1ns/1ps
`include "tile_render_params.svh"

module tile_render_asserts (
	input logic                  clock_50,
	input logic                  reset,
	input logic                  video_on,
	input tile_render_pkg::rgb_t rgb
);
	import tile_render_pkg::*;

	int failures = 0; // read by the testbench top

	// output register clears while reset is held
	reset_black: assert property (@(posedge clock_50) reset |=> rgb == {3{`COLOR_BLACK}})
		else begin
			failures++;
			$error("rgb is not black after a reset cycle");
		end

	// blanked sample reaches the output two edges later
	blank_pink: assert property (@(posedge clock_50)
		(!reset && !video_on) ##1 !reset |=> rgb == `COLOR_PINK)
		else begin
			failures++;
			$error("rgb is not pink for a blanked sample");
		end

endmodule

// File: tile_render.sv
`timescale 1ns/1ps

module tile_render (
	input  logic                      clock_50,
	input  logic                      reset,
	input  logic                      video_on,
	input  tile_render_pkg::pix_pos_t pix,
	output tile_render_pkg::rgb_t     rgb
);
	import tile_render_pkg::*;

	tile_req_t  tile_req;   // stage 1 register
	logic [2:0] pixel_code; // bitmap read, same cycle
	logic       on_border;

	// stage 1, map lookup and offsets
	tile_map_lookup tile_map_lookup_i (
		.clock_50 (clock_50),
		.reset    (reset),
		.video_on (video_on),
		.pix      (pix),
		.tile_req (tile_req)
	);

	sprite_bitmap_rom sprite_bitmap_rom_i (
		.tile_req   (tile_req),
		.pixel_code (pixel_code),
		.on_border  (on_border)
	);

	// stage 2, palette and output register
	pixel_colorizer pixel_colorizer_i (
		.clock_50   (clock_50),
		.reset      (reset),
		.tile_req   (tile_req),
		.pixel_code (pixel_code),
		.on_border  (on_border),
		.rgb        (rgb)
	);

endmodule

// File: pixel_colorizer.sv
`timescale 1ns/1ps
`include "tile_render_params.svh"

module pixel_colorizer (
	input  logic                       clock_50,
	input  logic                       reset,
	input  tile_render_pkg::tile_req_t tile_req,
	input  logic [2:0]                 pixel_code,
	input  logic                       on_border,
	output tile_render_pkg::rgb_t      rgb
);
	import tile_render_pkg::*;

	rgb_t rgb_next;

	// neutral shade, all channels equal
	function automatic rgb_t grey_level(input logic [7:0] level);
		return '{r: level, g: level, b: level};
	endfunction

	function automatic rgb_t robot_palette(input robot_color_e code);
		case (code)
			ROBOT_GREY:      return grey_level(`COLOR_GREY);
			ROBOT_BLACK:     return grey_level(`COLOR_BLACK);
			ROBOT_WHITE:     return grey_level(`COLOR_WHITE);
			ROBOT_DARK_GREY: return grey_level(`COLOR_DARK_GREY);
			ROBOT_YELLOW:    return `COLOR_YELLOW;
			ROBOT_RED:       return `COLOR_RED;
			ROBOT_BROWN:     return `COLOR_BROWN;
			default:         return grey_level(`COLOR_WHITE); // code 7 unused
		endcase
	endfunction

	function automatic rgb_t trash_palette(input trash_color_e code);
		case (code)
			TRASH_GREY,
			TRASH_GREY_ALT:  return grey_level(`COLOR_GREY);
			TRASH_BLACK:     return grey_level(`COLOR_BLACK);
			TRASH_DARK_GREY: return grey_level(`COLOR_DARK_GREY);
			TRASH_RED:       return `COLOR_RED;
			default:         return grey_level(`COLOR_WHITE);
		endcase
	endfunction

	// blanking first, then by tile kind
	always_comb begin
		if (!tile_req.video_on) begin
			rgb_next = `COLOR_PINK;
		end else begin
			case (tile_req.kind)
				TILE_ROBOT: rgb_next = robot_palette(robot_color_e'(pixel_code));
				TILE_TRASH: rgb_next = trash_palette(trash_color_e'(pixel_code));
				TILE_FREE_PATH: begin
					rgb_next = on_border ? grey_level(`COLOR_BLACK) : grey_level(`COLOR_GREY);
				end
				TILE_WALL: begin
					rgb_next = on_border ? grey_level(`COLOR_BLACK) : grey_level(`COLOR_WHITE);
				end
				default: rgb_next = `COLOR_BG_RED; // map codes 4..7
			endcase
		end
	end

	always_ff @(posedge clock_50) begin
		if (reset) begin
			rgb <= grey_level(`COLOR_BLACK);
		end else begin
			rgb <= rgb_next;
		end
	end

endmodule

// File: sprite_bitmap_rom.sv
`timescale 1ns/1ps
`include "tile_render_params.svh"

module sprite_bitmap_rom (
	input  tile_render_pkg::tile_req_t tile_req,
	output logic [2:0]                 pixel_code,
	output logic                       on_border
);
	import tile_render_pkg::*;

	// rows shared by both sprites
	localparam logic [0:95] EDGE_ROW  = 96'o1111_1111_1111_1111_1111_1111_1111_1111;
	localparam logic [0:95] BLANK_ROW = 96'o1000_0000_0000_0000_0000_0000_0000_0001;

	logic [0:95] robot_row;
	logic [0:95] trash_row;
	logic [6:0]  bit_pos;

	assign bit_pos = 7'(tile_req.off_x) * 7'd3;

	// robot, codes per robot_color_e
	always_comb begin
		case (tile_req.off_y)
			5'd0, 5'd31:  robot_row = EDGE_ROW;
			5'd4:         robot_row = 96'o1000_0000_0000_0100_0001_0000_0000_0001;
			5'd5:         robot_row = 96'o1000_0000_0000_1110_0011_1000_0000_0001;
			5'd6:         robot_row = 96'o1000_0000_0001_1211_1112_1100_0000_0001;
			5'd7:         robot_row = 96'o1000_0000_0011_2221_1122_2110_0000_0001;
			5'd8:         robot_row = 96'o1000_0000_0112_2221_1122_2211_0000_0001;
			5'd9:         robot_row = 96'o1000_0000_1122_1122_1221_1221_1000_0001;
			5'd10:        robot_row = 96'o1000_0001_1221_3212_1212_3122_1100_0001; // eyes
			5'd11:        robot_row = 96'o1000_0011_2221_3312_1213_3122_2110_0001;
			5'd12:        robot_row = 96'o1000_0012_2222_1122_1221_1222_2210_0001;
			5'd13, 5'd14: robot_row = 96'o1000_0012_2222_2221_6122_2222_2210_0001;
			5'd15:        robot_row = 96'o1000_0001_2222_2211_6112_2222_2100_0001;
			5'd16:        robot_row = 96'o1000_0000_1111_1111_6111_1111_1000_0001;
			5'd17:        robot_row = 96'o1000_0000_0000_0001_6100_0000_0000_0001; // neck
			5'd18:        robot_row = 96'o1000_0000_0006_6666_6666_6600_0000_0001;
			5'd19:        robot_row = 96'o1000_0000_6666_3333_3333_3666_6000_0001;
			5'd20:        robot_row = 96'o1000_0000_6336_6666_6666_6633_6000_0001;
			5'd21:        robot_row = 96'o1000_0000_6334_4111_1111_4433_6000_0001;
			5'd22:        robot_row = 96'o1000_0000_6364_4144_4441_4463_6000_0001;
			5'd23:        robot_row = 96'o1000_0000_0664_4144_4441_4466_0000_0001;
			5'd24:        robot_row = 96'o1000_0000_0114_4144_4551_4411_0000_0001;
			5'd25:        robot_row = 96'o1000_0000_0114_4444_4554_4411_0000_0001;
			5'd26, 5'd27: robot_row = 96'o1000_0000_0111_1100_0001_1111_0000_0001; // tracks
			default:      robot_row = BLANK_ROW;
		endcase
	end

	// trash bag, codes per trash_color_e
	always_comb begin
		case (tile_req.off_y)
			5'd0, 5'd31:  trash_row = EDGE_ROW;
			5'd4:         trash_row = 96'o1000_0000_0000_1100_0000_0000_0000_0001;
			5'd5:         trash_row = 96'o1000_0000_0001_3310_0000_0000_0000_0001;
			5'd6:         trash_row = 96'o1000_0000_0001_3231_0000_0000_0000_0001;
			5'd7:         trash_row = 96'o1000_0000_0001_3221_0000_0000_0000_0001;
			5'd8:         trash_row = 96'o1000_0000_0001_2210_0000_0000_0000_0001;
			5'd9:         trash_row = 96'o1000_0000_0001_1110_0000_0000_0000_0001; // knot
			5'd10:        trash_row = 96'o1000_0000_0112_2221_1000_0000_0000_0001;
			5'd11:        trash_row = 96'o1000_0000_1333_3332_2100_0000_0000_0001;
			5'd12:        trash_row = 96'o1000_0001_3333_3333_3211_0000_0000_0001;
			5'd13:        trash_row = 96'o1000_0013_3333_3333_3322_1000_0000_0001;
			5'd14:        trash_row = 96'o1000_0013_3333_3333_3322_2100_0000_0001;
			5'd15:        trash_row = 96'o1000_0013_3333_4443_3322_2100_0000_0001;
			5'd16:        trash_row = 96'o1000_0133_3333_4443_3322_2210_0000_0001;
			5'd17:        trash_row = 96'o1000_0133_3333_4443_3222_2210_0000_0001;
			5'd18:        trash_row = 96'o1000_0133_3333_4443_2222_2221_0000_0001;
			5'd19:        trash_row = 96'o1000_0133_3333_4442_2222_2221_0000_0001;
			5'd20:        trash_row = 96'o1000_1223_3333_4443_3222_2221_0000_0001;
			5'd21:        trash_row = 96'o1000_1333_3333_4443_3322_2221_0000_0001;
			5'd22:        trash_row = 96'o1000_1333_3333_3333_3322_2221_0000_0001;
			5'd23:        trash_row = 96'o1000_1233_3333_3333_3222_2221_0000_0001;
			5'd24:        trash_row = 96'o1000_0122_2333_3322_2222_2221_0000_0001;
			5'd25:        trash_row = 96'o1000_0012_2222_2222_2222_2210_0000_0001;
			5'd26:        trash_row = 96'o1000_0011_2222_2222_2211_1100_0000_0001;
			5'd27:        trash_row = 96'o1000_0000_1111_1111_1100_0000_0000_0001;
			default:      trash_row = BLANK_ROW;
		endcase
	end

	always_comb begin
		case (tile_req.kind)
			TILE_ROBOT: pixel_code = robot_row[bit_pos +: 3];
			TILE_TRASH: pixel_code = trash_row[bit_pos +: 3];
			default:    pixel_code = 3'd0; // not read for plain tiles
		endcase
	end

	// wall and free path only need the 1-pixel frame
	assign on_border = (tile_req.off_x == 5'd0) || (tile_req.off_x == 5'(`TILE_SIZE - 1)) ||
		(tile_req.off_y == 5'd0) || (tile_req.off_y == 5'(`TILE_SIZE - 1));

endmodule

// File: tile_map_lookup.sv
`timescale 1ns/1ps
`include "tile_render_params.svh"

module tile_map_lookup (
	input  logic                       clock_50,
	input  logic                       reset,
	input  logic                       video_on,
	input  tile_render_pkg::pix_pos_t  pix,
	output tile_render_pkg::tile_req_t tile_req
);
	import tile_render_pkg::*;

	// one octal digit per tile, column 0 leftmost
	localparam logic [0:59] MAP_TABLE [`MAP_DEFINED_ROWS] = '{
		60'o0000_0000_0111_1110_0000,
		60'o0000_0000_0100_0010_0000,
		60'o0000_0100_0300_0011_1111,
		60'o0000_0111_1100_0000_0000,
		60'o0000_0100_0100_0000_1111,
		60'o0000_0100_0100_0111_1000,
		60'o1111_1100_0411_1100_0000,
		60'o1001_1100_0000_1011_1111,
		60'o1000_0100_0000_1001_0000,
		60'o2001_1111_1101_1511_0000
	};

	logic [4:0] map_row;
	logic [4:0] map_col;
	logic [5:0] code_pos;
	logic [2:0] map_code;
	tile_kind_e kind_next;

	assign map_row  = pix.y[9:`TILE_BITS]; // y / tile size
	assign map_col  = pix.x[9:`TILE_BITS];
	assign code_pos = 6'(map_col) * 6'd3;  // 3 bits per tile

	always_comb begin
		map_code = 3'd0; // rows past the table draw as wall
		if (map_row < 5'(`MAP_DEFINED_ROWS) && map_col < 5'(`MAP_COLS)) begin
			map_code = MAP_TABLE[map_row[3:0]][code_pos +: 3];
		end
	end

	always_comb begin
		case (map_code)
			3'd0:    kind_next = TILE_WALL;
			3'd1:    kind_next = TILE_FREE_PATH;
			3'd2:    kind_next = TILE_ROBOT;
			3'd3:    kind_next = TILE_TRASH;
			default: kind_next = TILE_NONE; // 4..7, drawn red
		endcase
	end

	always_ff @(posedge clock_50) begin
		if (reset) begin
			tile_req <= '{kind: TILE_NONE, off_x: '0, off_y: '0, video_on: 1'b0};
		end else begin
			tile_req.kind     <= kind_next;
			tile_req.off_x    <= pix.x[`TILE_BITS-1:0]; // x mod tile size
			tile_req.off_y    <= pix.y[`TILE_BITS-1:0];
			tile_req.video_on <= video_on;
		end
	end

endmodule

// File: tile_render_pkg.sv
`include "tile_render_params.svh"

package tile_render_pkg;

	// raster position from the video timing block
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
	} pix_pos_t;

	// decoded map code
	typedef enum logic [2:0] {
		TILE_WALL      = 3'd0,
		TILE_FREE_PATH = 3'd1,
		TILE_ROBOT     = 3'd2,
		TILE_TRASH     = 3'd3,
		TILE_NONE      = 3'd4
	} tile_kind_e;

	// stage 1 result
	typedef struct packed {
		tile_kind_e             kind;
		logic [`TILE_BITS-1:0] off_x;
		logic [`TILE_BITS-1:0] off_y;
		logic                   video_on;
	} tile_req_t;

	typedef enum logic [2:0] {
		ROBOT_GREY      = 3'd0,
		ROBOT_BLACK     = 3'd1,
		ROBOT_WHITE     = 3'd2,
		ROBOT_DARK_GREY = 3'd3,
		ROBOT_YELLOW    = 3'd4,
		ROBOT_RED       = 3'd5,
		ROBOT_BROWN     = 3'd6
	} robot_color_e;

	typedef enum logic [2:0] {
		TRASH_GREY      = 3'd0,
		TRASH_BLACK     = 3'd1,
		TRASH_DARK_GREY = 3'd2,
		TRASH_GREY_ALT  = 3'd3, // same shade as code 0
		TRASH_RED       = 3'd4
	} trash_color_e;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

endpackage

// File: tile_render_params.svh
`ifndef TILE_RENDER_PARAMS_SVH
`define TILE_RENDER_PARAMS_SVH

// tile geometry
`define TILE_SIZE 32
`define TILE_BITS 5

// map geometry in tiles, 640x480 screen
`define MAP_COLS 20
`define MAP_ROWS 15
`define MAP_DEFINED_ROWS 10 // rows below this one are solid wall

// grey levels, used for all three channels
`define COLOR_GREY      8'd190
`define COLOR_DARK_GREY 8'd168
`define COLOR_WHITE     8'd255
`define COLOR_BLACK     8'd0

// full rgb triples, r in the top byte
`define COLOR_YELLOW    {8'd255, 8'd255, 8'd0}
`define COLOR_RED       {8'd255, 8'd0, 8'd0}
`define COLOR_BROWN     {8'd92, 8'd64, 8'd51}
`define COLOR_PINK      {8'd255, 8'd0, 8'd255}   // blanking
`define COLOR_BG_RED    {8'd255, 8'd0, 8'd0}     // unknown map code

`endif
